/* design/ip_bridge_pkg.sv */
package ip_bridge_pkg;

    // IP header fields used on transmit.
    localparam logic [15:0] IP_HDR_BYTES = 16'd20;
    localparam logic [7:0]  IP_TTL       = 8'd64;
    localparam logic [7:0]  IP_PROTO     = 8'd17; // UDP.

    localparam int FIFO_AW    = 11;
    localparam int FIFO_DEPTH = 1 << FIFO_AW;

    localparam int NUM_TOPICS = 8; // Also the width of the topic mask.

    // APB register map, byte addresses.
    typedef enum logic [7:0] {
        REG_LOCAL_IP   = 8'h00,
        REG_PEER_IP    = 8'h04,
        REG_TOPIC_MASK = 8'h08,
        REG_FWD_COUNT  = 8'h0C,
        REG_DROP_COUNT = 8'h10
    } reg_addr_e;

    typedef enum logic [2:0] {RX_IDLE, RX_LEN_HI, RX_LEN_LO, RX_DATA, RX_DRAIN} rx_state_e;

    typedef enum logic [2:0] {FLT_LEN_HI, FLT_LEN_LO, FLT_TOPIC, FLT_FWD, FLT_DROP} flt_state_e;

    typedef enum logic [1:0] {TX_LEN_HI, TX_LEN_LO, TX_HDR, TX_DATA} tx_state_e;

endpackage

/* design/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo #(
    parameter int DEPTH = ip_bridge_pkg::FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  logic [7:0] din,
    output logic       full,
    input  logic       rd_en,
    output logic [7:0] dout,
    output logic       empty
);
    localparam int AW = $clog2(DEPTH);

    logic [7:0]  mem [DEPTH];
    logic [AW:0] wr_ptr; // Extra MSB tells a full buffer from an empty one.
    logic [AW:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign dout  = mem[rd_ptr[AW-1:0]]; // Head byte, valid while not empty.

endmodule

/* design/ip_rx_unpack.sv */
`timescale 1ns/1ps

module ip_rx_unpack (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,
    input  logic [15:0] rx_ip_length,
    input  logic [31:0] rx_ip_dest_ip,
    input  logic [7:0]  rx_payload_tdata,
    input  logic        rx_payload_tvalid,
    input  logic        rx_payload_tlast,
    output logic        rx_payload_tready,
    input  logic [31:0] local_ip,
    input  logic        fifo_full,
    output logic        fifo_wr_en,
    output logic [7:0]  fifo_din,
    output logic        rx_drop
);
    import ip_bridge_pkg::*;

    rx_state_e   state;
    logic [15:0] pay_len;
    logic        hdr_acc;
    logic        beat;

    assign hdr_acc = rx_hdr_valid && rx_hdr_ready;
    assign beat    = rx_payload_tvalid && rx_payload_tready;
    assign rx_drop = hdr_acc && (rx_ip_dest_ip != local_ip); // Not for us.

    always_comb begin
        rx_hdr_ready      = 1'b0;
        rx_payload_tready = 1'b0;
        fifo_wr_en        = 1'b0;
        fifo_din          = rx_payload_tdata;
        case (state)
            RX_IDLE:   rx_hdr_ready = 1'b1;
            RX_LEN_HI: begin
                fifo_wr_en = !fifo_full;
                fifo_din   = pay_len[15:8]; // Length prefix, big endian.
            end
            RX_LEN_LO: begin
                fifo_wr_en = !fifo_full;
                fifo_din   = pay_len[7:0];
            end
            RX_DATA: begin
                rx_payload_tready = !fifo_full;
                fifo_wr_en        = rx_payload_tvalid && !fifo_full;
            end
            RX_DRAIN:  rx_payload_tready = !fifo_full; // Discard the payload.
            default:   ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (hdr_acc && rx_drop) state <= RX_DRAIN;
                    else if (hdr_acc) state <= RX_LEN_HI;
                end
                RX_LEN_HI: if (!fifo_full) state <= RX_LEN_LO;
                RX_LEN_LO: if (!fifo_full) state <= RX_DATA;
                default:   if (beat && rx_payload_tlast) state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_acc) pay_len <= rx_ip_length - IP_HDR_BYTES;
    end

endmodule

/* design/topic_filter.sv */
`timescale 1ns/1ps

module topic_filter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [7:0]                           in_dout,
    input  logic                                 in_empty,
    output logic                                 in_rd_en,
    input  logic                                 out_full,
    output logic                                 out_wr_en,
    output logic [7:0]                           out_din,
    input  logic [ip_bridge_pkg::NUM_TOPICS-1:0] topic_mask,
    output logic                                 fwd_pulse,
    output logic                                 drop_pulse
);
    import ip_bridge_pkg::*;

    localparam int TW = $clog2(NUM_TOPICS);

    flt_state_e  state;
    logic [15:0] len;      // Bytes left in the message, topic included.
    logic [1:0]  hdr_left; // Length bytes still to be written.
    logic        keep;
    logic        last;

    // The topic byte is peeked at the FIFO head, not popped.
    assign keep       = (in_dout < NUM_TOPICS) && topic_mask[in_dout[TW-1:0]];
    assign fwd_pulse  = (state == FLT_TOPIC) && !in_empty && keep;
    assign drop_pulse = (state == FLT_TOPIC) && !in_empty && !keep;
    assign last       = (len == 16'd1);

    always_comb begin
        in_rd_en  = 1'b0;
        out_wr_en = 1'b0;
        out_din   = in_dout;
        case (state)
            FLT_LEN_HI, FLT_LEN_LO: in_rd_en = !in_empty;
            FLT_FWD: begin
                if (hdr_left != 2'd0) begin
                    out_wr_en = !out_full;
                    out_din   = (hdr_left == 2'd2) ? len[15:8] : len[7:0];
                end else begin
                    in_rd_en  = !in_empty && !out_full;
                    out_wr_en = !in_empty && !out_full;
                end
            end
            FLT_DROP: in_rd_en = !in_empty;
            default:  ;
        endcase
    end

    // ############################
    // Message FSM.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= FLT_LEN_HI;
            len      <= '0;
            hdr_left <= '0;
        end else begin
            case (state)
                FLT_LEN_HI: begin
                    if (in_rd_en) begin
                        len[15:8] <= in_dout;
                        state     <= FLT_LEN_LO;
                    end
                end
                FLT_LEN_LO: begin
                    if (in_rd_en) begin
                        len[7:0] <= in_dout;
                        state    <= FLT_TOPIC;
                    end
                end
                FLT_TOPIC: begin
                    hdr_left <= 2'd2;
                    if (fwd_pulse) state <= FLT_FWD;
                    else if (drop_pulse) state <= FLT_DROP;
                end
                default: begin
                    if (state == FLT_FWD && hdr_left != 2'd0) begin
                        if (out_wr_en) hdr_left <= hdr_left - 2'd1;
                    end else if (in_rd_en) begin
                        len <= len - 16'd1;
                        if (last) state <= FLT_LEN_HI; // End of message.
                    end
                end
            endcase
        end
    end

endmodule

/* design/ip_tx_pack.sv */
`timescale 1ns/1ps

module ip_tx_pack (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  fifo_dout,
    input  logic        fifo_empty,
    output logic        fifo_rd_en,
    input  logic [31:0] local_ip,
    input  logic [31:0] peer_ip,
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    output logic [15:0] tx_ip_length,
    output logic [7:0]  tx_ip_ttl,
    output logic [7:0]  tx_ip_protocol,
    output logic [31:0] tx_ip_source_ip,
    output logic [31:0] tx_ip_dest_ip,
    output logic [7:0]  tx_payload_tdata,
    output logic        tx_payload_tvalid,
    output logic        tx_payload_tlast,
    input  logic        tx_payload_tready
);
    import ip_bridge_pkg::*;

    tx_state_e   state;
    logic [7:0]  len_hi;
    logic [15:0] count; // Payload bytes still to send.
    logic        beat;
    logic        len_rd;

    assign tx_ip_ttl         = IP_TTL;
    assign tx_ip_protocol    = IP_PROTO;
    assign tx_hdr_valid      = (state == TX_HDR);
    assign tx_payload_tvalid = (state == TX_DATA) && !fifo_empty;
    assign tx_payload_tdata  = fifo_dout;
    assign tx_payload_tlast  = (state == TX_DATA) && (count == 16'd1);

    assign beat       = tx_payload_tvalid && tx_payload_tready;
    assign len_rd     = (state == TX_LEN_HI || state == TX_LEN_LO) && !fifo_empty;
    assign fifo_rd_en = len_rd || beat;

    // Header fields stay put until the next length prefix is read.
    always_ff @(posedge clk) begin
        if (len_rd && state == TX_LEN_HI) len_hi <= fifo_dout;
        if (len_rd && state == TX_LEN_LO) begin
            tx_ip_length    <= {len_hi, fifo_dout} + IP_HDR_BYTES;
            tx_ip_source_ip <= local_ip;
            tx_ip_dest_ip   <= peer_ip;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= TX_LEN_HI;
            count <= '0;
        end else begin
            case (state)
                TX_LEN_HI: if (len_rd) state <= TX_LEN_LO;
                TX_LEN_LO: begin
                    if (len_rd) begin
                        count <= {len_hi, fifo_dout};
                        state <= TX_HDR;
                    end
                end
                TX_HDR:    if (tx_hdr_ready) state <= TX_DATA;
                default: begin
                    if (beat) begin
                        count <= count - 16'd1;
                        if (tx_payload_tlast) state <= TX_LEN_HI;
                    end
                end
            endcase
        end
    end

endmodule

/* design/bridge_regs.sv */
`timescale 1ns/1ps

module bridge_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [7:0]                           paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [31:0]                          pwdata,
    output logic [31:0]                          prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  logic                                 fwd_pulse,
    input  logic                                 drop_pulse,
    input  logic                                 rx_drop,
    output logic [31:0]                          local_ip,
    output logic [31:0]                          peer_ip,
    output logic [ip_bridge_pkg::NUM_TOPICS-1:0] topic_mask
);
    import ip_bridge_pkg::*;

    logic [31:0] fwd_count;
    logic [31:0] drop_count;
    logic        access;
    logic        mapped;
    logic        is_counter;
    logic        wr_ok;

    assign access  = psel && penable;
    assign pready  = 1'b1; // No wait states.
    assign pslverr = access && (!mapped || (pwrite && is_counter));
    assign wr_ok   = access && pwrite && mapped && !is_counter;

    always_comb begin
        mapped     = 1'b1;
        is_counter = 1'b0;
        prdata     = '0;
        case (paddr)
            REG_LOCAL_IP:   prdata = local_ip;
            REG_PEER_IP:    prdata = peer_ip;
            REG_TOPIC_MASK: prdata = {{(32 - NUM_TOPICS){1'b0}}, topic_mask};
            REG_FWD_COUNT: begin
                prdata     = fwd_count;
                is_counter = 1'b1; // Read only.
            end
            REG_DROP_COUNT: begin
                prdata     = drop_count;
                is_counter = 1'b1;
            end
            default: mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            local_ip   <= '0;
            peer_ip    <= '0;
            topic_mask <= '0;
            fwd_count  <= '0;
            drop_count <= '0;
        end else begin
            if (wr_ok && paddr == REG_LOCAL_IP)   local_ip <= pwdata;
            if (wr_ok && paddr == REG_PEER_IP)    peer_ip <= pwdata;
            if (wr_ok && paddr == REG_TOPIC_MASK) topic_mask <= pwdata[NUM_TOPICS-1:0];
            // Counters wrap; both drop sources may fire in one cycle.
            fwd_count  <= fwd_count + 32'(fwd_pulse);
            drop_count <= drop_count + 32'(rx_drop) + 32'(drop_pulse);
        end
    end

endmodule

/* design/ip_bridge_top.sv */
`timescale 1ns/1ps

module ip_bridge_top (
    input  logic        clk,
    input  logic        rst_n,
    // IP receive from the stack.
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,
    input  logic [15:0] rx_ip_length,
    input  logic [31:0] rx_ip_dest_ip,
    input  logic [7:0]  rx_payload_tdata,
    input  logic        rx_payload_tvalid,
    input  logic        rx_payload_tlast,
    output logic        rx_payload_tready,
    // IP transmit to the stack.
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    output logic [15:0] tx_ip_length,
    output logic [7:0]  tx_ip_ttl,
    output logic [7:0]  tx_ip_protocol,
    output logic [31:0] tx_ip_source_ip,
    output logic [31:0] tx_ip_dest_ip,
    output logic [7:0]  tx_payload_tdata,
    output logic        tx_payload_tvalid,
    output logic        tx_payload_tlast,
    input  logic        tx_payload_tready,
    // APB.
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    logic        rx_fifo_wr_en, rx_fifo_full, rx_fifo_rd_en, rx_fifo_empty;
    logic [7:0]  rx_fifo_din, rx_fifo_dout;
    logic        tx_fifo_wr_en, tx_fifo_full, tx_fifo_rd_en, tx_fifo_empty;
    logic [7:0]  tx_fifo_din, tx_fifo_dout;
    logic        rx_drop, fwd_pulse, drop_pulse;
    logic [31:0] local_ip, peer_ip;
    logic [7:0]  topic_mask;

    // ############################
    // Receive path.
    ip_rx_unpack i_rx_unpack (
        .clk, .rst_n, .rx_hdr_valid, .rx_hdr_ready, .rx_ip_length, .rx_ip_dest_ip,
        .rx_payload_tdata, .rx_payload_tvalid, .rx_payload_tlast, .rx_payload_tready,
        .local_ip, .fifo_full(rx_fifo_full), .fifo_wr_en(rx_fifo_wr_en),
        .fifo_din(rx_fifo_din), .rx_drop
    );

    byte_fifo i_rx_fifo (
        .clk, .rst_n, .wr_en(rx_fifo_wr_en), .din(rx_fifo_din), .full(rx_fifo_full),
        .rd_en(rx_fifo_rd_en), .dout(rx_fifo_dout), .empty(rx_fifo_empty)
    );

    topic_filter i_filter (
        .clk, .rst_n, .in_dout(rx_fifo_dout), .in_empty(rx_fifo_empty),
        .in_rd_en(rx_fifo_rd_en), .out_full(tx_fifo_full), .out_wr_en(tx_fifo_wr_en),
        .out_din(tx_fifo_din), .topic_mask, .fwd_pulse, .drop_pulse
    );

    // ############################
    // Transmit path.
    byte_fifo i_tx_fifo (
        .clk, .rst_n, .wr_en(tx_fifo_wr_en), .din(tx_fifo_din), .full(tx_fifo_full),
        .rd_en(tx_fifo_rd_en), .dout(tx_fifo_dout), .empty(tx_fifo_empty)
    );

    ip_tx_pack i_tx_pack (
        .clk, .rst_n, .fifo_dout(tx_fifo_dout), .fifo_empty(tx_fifo_empty),
        .fifo_rd_en(tx_fifo_rd_en), .local_ip, .peer_ip, .tx_hdr_valid, .tx_hdr_ready,
        .tx_ip_length, .tx_ip_ttl, .tx_ip_protocol, .tx_ip_source_ip, .tx_ip_dest_ip,
        .tx_payload_tdata, .tx_payload_tvalid, .tx_payload_tlast, .tx_payload_tready
    );

    bridge_regs i_regs (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .pslverr, .fwd_pulse, .drop_pulse, .rx_drop, .local_ip, .peer_ip, .topic_mask
    );

endmodule

/* verification/ip_bridge_assert.sv */
`timescale 1ns/1ps

module ip_bridge_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        tx_hdr_valid,
    input logic        tx_hdr_ready,
    input logic [15:0] tx_ip_length,
    input logic [31:0] tx_ip_source_ip,
    input logic [31:0] tx_ip_dest_ip,
    input logic [7:0]  tx_payload_tdata,
    input logic        tx_payload_tvalid,
    input logic        tx_payload_tlast,
    input logic        tx_payload_tready,
    input logic        pready,
    input logic        rx_payload_tready,
    input logic        rx_fifo_full
);

    hdr_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid)
        else $error("tx_hdr_valid fell before the header was accepted.");

    hdr_fields_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tx_hdr_valid && !tx_hdr_ready |=> $stable(tx_ip_length)
            && $stable(tx_ip_source_ip) && $stable(tx_ip_dest_ip))
        else $error("Header fields changed while the header was stalled.");

    // Payload beat must wait unchanged for tready.
    pay_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tx_payload_tvalid && !tx_payload_tready |=> tx_payload_tvalid
            && $stable(tx_payload_tdata) && $stable(tx_payload_tlast))
        else $error("Payload beat changed or vanished while stalled.");

    apb_no_wait: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else $error("APB pready went low.");

    rx_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        rx_fifo_full |-> !rx_payload_tready)
        else $error("rx_payload_tready high while the receive FIFO is full.");

endmodule

bind ip_bridge_top ip_bridge_assert i_assert (
    .clk(clk),
    .rst_n(rst_n),
    .tx_hdr_valid(tx_hdr_valid),
    .tx_hdr_ready(tx_hdr_ready),
    .tx_ip_length(tx_ip_length),
    .tx_ip_source_ip(tx_ip_source_ip),
    .tx_ip_dest_ip(tx_ip_dest_ip),
    .tx_payload_tdata(tx_payload_tdata),
    .tx_payload_tvalid(tx_payload_tvalid),
    .tx_payload_tlast(tx_payload_tlast),
    .tx_payload_tready(tx_payload_tready),
    .pready(pready),
    .rx_payload_tready(rx_payload_tready),
    .rx_fifo_full(rx_fifo_full)
);

/* verification/ip_bridge_tb.sv */
`timescale 1ns/1ps

module ip_bridge_tb;
    import ip_bridge_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        rx_hdr_valid, rx_hdr_ready;
    logic [15:0] rx_ip_length;
    logic [31:0] rx_ip_dest_ip;
    logic [7:0]  rx_payload_tdata;
    logic        rx_payload_tvalid, rx_payload_tlast, rx_payload_tready;
    logic        tx_hdr_valid, tx_hdr_ready;
    logic [15:0] tx_ip_length;
    logic [7:0]  tx_ip_ttl, tx_ip_protocol;
    logic [31:0] tx_ip_source_ip, tx_ip_dest_ip;
    logic [7:0]  tx_payload_tdata;
    logic        tx_payload_tvalid, tx_payload_tlast, tx_payload_tready;
    logic [7:0]  paddr;
    logic        psel, penable, pwrite;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;

    int          seed = 32;
    int          errors = 0;
    int          total_bytes = 0;
    int          limit_cycles = 0;
    int          num_fwd = 0;
    int          num_drop = 0;
    int          rcv_pkts = 0;
    int          remaining = 0;
    logic        bp_on = 1'b0;
    logic [31:0] cfg_local, cfg_peer;
    logic [7:0]  cfg_mask;

    logic [31:0] pk_dest[$];
    logic [15:0] pk_len[$];
    logic        pk_bp[$];
    logic [7:0]  stim_bytes[$];
    logic [15:0] exp_len[$]; // Payload lengths of packets due on transmit.
    logic [7:0]  exp_bytes[$];

    ip_bridge_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Setup phase on one falling edge, access phase on the next.
    task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic load_testdata(output logic ok);
        int            fd;
        int            code;
        int            i;
        int            first;
        logic [63:0]   kind;
        logic [1023:0] rest;
        logic [31:0]   dest;
        logic [31:0]   r;
        logic [15:0]   len;
        logic [7:0]    topic;
        logic          bp;
        ok = 1'b0;
        bp = 1'b0;
        fd = $fopen("verification/ip_bridge_testdata.txt", "r");
        if (fd == 0) return;
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "R") begin
                code = $fscanf(fd, "%h %h %h", cfg_local, cfg_peer, cfg_mask);
                assert (code == 3) else begin
                    $display("A register line in the test data file is incomplete.");
                    errors++;
                end
            end else if (kind == "B") begin
                bp = 1'b1;
            end else if (kind == "P") begin
                code = $fscanf(fd, "%h %h %h", dest, len, topic);
                assert (code == 3) else begin
                    $display("A packet line in the test data file is incomplete.");
                    errors++;
                end
                pk_dest.push_back(dest);
                pk_len.push_back(len);
                pk_bp.push_back(bp);
                total_bytes += len;
                first = stim_bytes.size();
                stim_bytes.push_back(topic); // Topic id leads the payload.
                for (i = 1; i < len; i++) begin
                    r = $random(seed);
                    stim_bytes.push_back(r[7:0]);
                end
                if (dest == cfg_local && topic < 8 && cfg_mask[topic[2:0]]) begin
                    num_fwd++;
                    exp_len.push_back(len);
                    for (i = first; i < stim_bytes.size(); i++) exp_bytes.push_back(stim_bytes[i]);
                end else begin
                    num_drop++;
                end
            end else begin
                $display("Unknown line type in the test data file.");
                errors++;
            end
        end
        $fclose(fd);
        ok = 1'b1;
    endtask

    task automatic send_packet(input logic [31:0] dest, input logic [15:0] len);
        int i;
        @(negedge clk);
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        rx_hdr_valid      = 1'b1;
        rx_ip_length      = len + 16'd20;
        rx_ip_dest_ip     = dest;
        #1;
        while (!rx_hdr_ready) begin
            @(negedge clk);
            #1;
        end
        for (i = 0; i < len; i++) begin
            @(negedge clk);
            rx_hdr_valid      = 1'b0;
            rx_payload_tvalid = 1'b1;
            rx_payload_tdata  = stim_bytes.pop_front();
            rx_payload_tlast  = (i == len - 1);
            #1;
            while (!rx_payload_tready) begin
                @(negedge clk);
                #1;
            end
        end
    endtask

    // ############################
    // Transmit side receiver.
    initial begin
        logic [31:0] r;
        logic [15:0] plen;
        tx_hdr_ready      = 1'b0;
        tx_payload_tready = 1'b0;
        wait (rst_n);
        forever begin
            @(negedge clk);
            r = $random(seed);
            tx_hdr_ready      = bp_on ? r[0] : 1'b1;
            tx_payload_tready = bp_on ? (r[1] | r[2]) : 1'b1;
            #1;
            if (tx_hdr_valid && tx_hdr_ready) begin
                assert (exp_len.size() > 0) else begin
                    $display("An output packet appeared that no input should produce.");
                    errors++;
                end
                if (exp_len.size() > 0) begin
                    plen = exp_len.pop_front();
                    check_value("tx_ip_length", plen + 16'd20, tx_ip_length);
                    check_value("tx_ip_source_ip", cfg_local, tx_ip_source_ip);
                    check_value("tx_ip_dest_ip", cfg_peer, tx_ip_dest_ip);
                    check_value("tx_ip_ttl", 8'd64, tx_ip_ttl);
                    check_value("tx_ip_protocol", 8'd17, tx_ip_protocol);
                    remaining = plen;
                end
            end
            if (tx_payload_tvalid && tx_payload_tready) begin
                assert (remaining > 0 && exp_bytes.size() > 0) else begin
                    $display("A payload byte was sent outside of an expected packet.");
                    errors++;
                end
                if (remaining > 0 && exp_bytes.size() > 0) begin
                    check_value("tx_payload_tdata", exp_bytes.pop_front(), tx_payload_tdata);
                    check_value("tx_payload_tlast", remaining == 1, tx_payload_tlast);
                    remaining--;
                    if (remaining == 0) rcv_pkts++;
                end
            end
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: only %0d of %0d output packets arrived.", rcv_pkts, num_fwd);
        $display("Errors: %0d", errors + 1);
        $display("=== FAIL ===");
        $finish;
    end

    // ############################
    // Main sequence.
    initial begin
        logic        ok;
        logic        err;
        logic [31:0] rd;
        logic [31:0] fwd_cnt;
        logic [31:0] drop_cnt;
        int          i;
        rst_n             = 1'b0;
        rx_hdr_valid      = 1'b0;
        rx_ip_length      = '0;
        rx_ip_dest_ip     = '0;
        rx_payload_tdata  = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        paddr             = '0;
        psel              = 1'b0;
        penable           = 1'b0;
        pwrite            = 1'b0;
        pwdata            = '0;
        load_testdata(ok);
        if (!ok) begin
            $display("Could not open the test data file.");
            $display("=== FAIL ===");
            $finish;
        end else begin
            limit_cycles = total_bytes * 8 + 2000;
            repeat (3) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;

            apb_access(REG_LOCAL_IP, 1'b1, cfg_local, rd, err);
            check_value("pslverr", 0, err);
            apb_access(REG_PEER_IP, 1'b1, cfg_peer, rd, err);
            check_value("pslverr", 0, err);
            apb_access(REG_TOPIC_MASK, 1'b1, {24'h0, cfg_mask}, rd, err);
            check_value("pslverr", 0, err);
            apb_access(REG_LOCAL_IP, 1'b0, '0, rd, err);
            check_value("prdata", cfg_local, rd);
            apb_access(REG_PEER_IP, 1'b0, '0, rd, err);
            check_value("prdata", cfg_peer, rd);
            apb_access(REG_TOPIC_MASK, 1'b0, '0, rd, err);
            check_value("prdata", {24'h0, cfg_mask}, rd);
            apb_access(8'h14, 1'b0, '0, rd, err); // Unmapped.
            check_value("pslverr", 1, err);
            apb_access(REG_FWD_COUNT, 1'b1, 32'h0000_1234, rd, err);
            check_value("pslverr", 1, err);
            apb_access(REG_FWD_COUNT, 1'b0, '0, rd, err);
            check_value("prdata", 0, rd);
            apb_access(REG_DROP_COUNT, 1'b0, '0, rd, err);
            check_value("prdata", 0, rd);

            for (i = 0; i < pk_dest.size(); i++) begin
                bp_on = pk_bp[i];
                send_packet(pk_dest[i], pk_len[i]);
            end
            @(negedge clk);
            rx_payload_tvalid = 1'b0;
            rx_payload_tlast  = 1'b0;

            // Every packet ends in exactly one counter event.
            fwd_cnt  = '0;
            drop_cnt = '0;
            while (fwd_cnt + drop_cnt < pk_dest.size()) begin
                apb_access(REG_FWD_COUNT, 1'b0, '0, fwd_cnt, err);
                apb_access(REG_DROP_COUNT, 1'b0, '0, drop_cnt, err);
            end
            check_value("fwd_count", num_fwd, fwd_cnt);
            check_value("drop_count", num_drop, drop_cnt);
            wait (rcv_pkts == num_fwd);
            repeat (20) @(negedge clk);

            $display("Errors: %0d, packets forwarded: %0d of %0d", errors, rcv_pkts, num_fwd);
            if (errors == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

/* ip_bridge.f */
design/ip_bridge_pkg.sv
design/byte_fifo.sv
design/ip_rx_unpack.sv
design/topic_filter.sv
design/ip_tx_pack.sv
design/bridge_regs.sv
design/ip_bridge_top.sv
verification/ip_bridge_assert.sv
verification/ip_bridge_tb.sv

/* Bender.yml */
package:
  name: ip_bridge

sources:
  - design/ip_bridge_pkg.sv
  - design/byte_fifo.sv
  - design/ip_rx_unpack.sv
  - design/topic_filter.sv
  - design/ip_tx_pack.sv
  - design/bridge_regs.sv
  - design/ip_bridge_top.sv
  - target: test
    files:
      - verification/ip_bridge_assert.sv
      - verification/ip_bridge_tb.sv

/* verification/ip_bridge_testdata.txt */
# R local_ip peer_ip topic_mask | P dest_ip payload_len topic | B turns on tx back-pressure
# All fields hex; payload_len counts the topic byte.
R c0a80a01 c0a80a02 a5
P c0a80a01 0010 00
P c0a80a01 0008 01
P c0a80a01 0020 02
P c0a80a01 000c 09
P c0a80a07 0010 00
P c0a80a01 0001 05
P c0a80a01 0018 ff
P 0a000001 0014 07
B
P c0a80a01 0030 07
P c0a80a01 0004 00
P c0a80a01 0011 03
P c0a80a01 0040 05
P c0a80a01 0002 02
P 0a000001 0006 02
